// ==== verilog/ac97_link_pkg.sv ====
package ac97_link_pkg;

  ////////////////////
  // frame geometry
  ////////////////////
  localparam int frame_bits = 256;  // bits per ac97 frame
  localparam int slot_bits  = 20;   // pcm / command slot width

  typedef logic [7:0]  bit_count_t;  // position within a frame
  typedef logic [19:0] slot_t;       // one slot payload, msb first
  typedef logic [7:0]  cmd_addr_t;   // codec register address
  typedef logic [15:0] cmd_data_t;   // codec register data

  // slot boundaries, as frame bit positions
  localparam bit_count_t tag_last       = 8'd15;  // slot 0 ends
  localparam bit_count_t cmd_addr_first = 8'd16;  // slot 1
  localparam bit_count_t cmd_data_first = 8'd36;  // slot 2
  localparam bit_count_t left_first     = 8'd56;  // slot 3
  localparam bit_count_t right_first    = 8'd76;  // slot 4
  localparam bit_count_t right_last     = 8'd95;  // everything after is zero

  ////////////////////
  // link ready window
  ////////////////////
  // high from mid frame until just after the next frame starts
  localparam bit_count_t ready_rise_bit = 8'd128;
  localparam bit_count_t ready_fall_bit = 8'd2;

endpackage

// ==== verilog/codec_ctrl_pkg.sv ====
package codec_ctrl_pkg;
  import ac97_link_pkg::*;

  typedef logic [4:0]  volume_t;  // 0 = quietest, 31 = loudest
  typedef logic [11:0] sample_t;  // user audio sample

  localparam volume_t volume_max   = 5'd31;
  localparam volume_t volume_reset = 5'd8;  // power-up volume

  ////////////////////
  // codec registers
  ////////////////////
  localparam cmd_addr_t reg_read_id       = 8'h80;  // read of reg 00 (vendor id)
  localparam cmd_addr_t reg_headphone_vol = 8'h04;
  localparam cmd_addr_t reg_pcm_vol       = 8'h18;
  localparam cmd_addr_t reg_record_select = 8'h1A;
  localparam cmd_addr_t reg_record_gain   = 8'h1C;
  localparam cmd_addr_t reg_mic_gain      = 8'h0E;
  localparam cmd_addr_t reg_beep_vol      = 8'h0A;
  localparam cmd_addr_t reg_general       = 8'h20;
  localparam cmd_addr_t reg_ext_audio     = 8'h2A;
  localparam cmd_addr_t reg_adc_rate      = 8'h32;

  // fixed data words
  localparam cmd_data_t read_id_data      = 16'h0000;
  localparam cmd_data_t pcm_vol_data      = 16'h0808;  // 0 db-ish both channels
  localparam cmd_data_t record_gain_data  = 16'h0F0F;  // max gain
  localparam cmd_data_t mic_gain_data     = 16'h8048;  // +20 db boost
  localparam cmd_data_t beep_vol_data     = 16'h0000;
  localparam cmd_data_t general_data      = 16'h8000;  // pcm out bypasses mix1
  localparam cmd_data_t ext_audio_data    = 16'h0001;  // variable rate on
  localparam cmd_data_t adc_rate_data     = 16'h5DC0;  // 24000 hz

  localparam logic [2:0] source_mic = 3'd0;  // record select code

  typedef enum logic [3:0] {
    st_read_id0, st_read_id1, st_idle2, st_headphone, st_idle4, st_pcm_vol,
    st_record_select, st_record_gain, st_idle8, st_mic_gain, st_beep_vol,
    st_pcm_bypass, st_ext_audio, st_adc_rate, st_idle14, st_idle15
  } cmd_state_t;

endpackage

// ==== verilog/button_debounce.sv ====
`timescale 1ns/1ps

module button_debounce #(
  parameter int debounce_cycles = 270000
) (
  input  logic clock_27mhz,
  input  logic reset,
  input  logic noisy,
  output logic clean
);

  localparam int count_bits = $clog2(debounce_cycles + 1);
  localparam logic [count_bits-1:0] stable_count = count_bits'(debounce_cycles);

  logic [count_bits-1:0] count;  // cycles since last change
  logic                  level;  // last sampled input

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      // start out agreeing with the pin
      count <= '0;
      level <= noisy;
      clean <= noisy;
    end else if (noisy != level) begin
      level <= noisy;  // bounce, start over
      count <= '0;
    end else if (count == stable_count) begin
      clean <= level;  // held long enough
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

// ==== verilog/volume_control.sv ====
`timescale 1ns/1ps

module volume_control import codec_ctrl_pkg::*; #(
  parameter int debounce_cycles = 270000
) (
  input  logic    clock_27mhz,
  input  logic    reset,
  input  logic    button_up,    // active low
  input  logic    button_down,  // active low
  output volume_t volume
);

  logic up_level, down_level;  // debounced, high = pressed
  logic up_prev, down_prev;
  logic up_press, down_press;

  button_debounce #(.debounce_cycles(debounce_cycles)) u_debounce_up (
    .clock_27mhz(clock_27mhz), .reset(reset), .noisy(~button_up), .clean(up_level)
  );

  button_debounce #(.debounce_cycles(debounce_cycles)) u_debounce_down (
    .clock_27mhz(clock_27mhz), .reset(reset), .noisy(~button_down), .clean(down_level)
  );

  assign up_press   = up_level & ~up_prev;      // rising edge of debounced level
  assign down_press = down_level & ~down_prev;

  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      volume    <= volume_reset;
      up_prev   <= 1'b1;  // a button held through reset is not a press
      down_prev <= 1'b1;
    end else begin
      up_prev   <= up_level;
      down_prev <= down_level;
      // saturate at both ends
      if (up_press && volume != volume_max)
        volume <= volume + 1'b1;
      else if (down_press && volume != '0)
        volume <= volume - 1'b1;
    end
  end

endmodule

// ==== verilog/codec_command_sequencer.sv ====
`timescale 1ns/1ps

module codec_command_sequencer import ac97_link_pkg::*, codec_ctrl_pkg::*; (
  input  logic      clock_27mhz,
  input  logic      reset,
  input  logic      ready,            // one pulse per frame
  input  volume_t   volume,
  output cmd_addr_t command_address,
  output cmd_data_t command_data,
  output logic      command_valid
);

  cmd_state_t state;
  volume_t    attenuation;

  // codec wants attenuation, 0 = loudest
  assign attenuation = volume_max - volume;

  ////////////////////
  // state step
  ////////////////////
  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      state         <= st_read_id0;
      command_valid <= 1'b0;
    end else begin
      if (ready)
        state <= (state == st_idle15) ? st_read_id0 : cmd_state_t'(state + 4'd1);
      if (state == st_read_id0)
        command_valid <= 1'b1;  // stays on until reset
    end
  end

  ////////////////////
  // command word
  ////////////////////
  // registered, so it follows the state by one cycle
  always_ff @(posedge clock_27mhz) begin
    case (state)
      st_headphone: begin
        command_address <= reg_headphone_vol;
        command_data    <= {3'b000, attenuation, 3'b000, attenuation};  // left, right
      end
      st_pcm_vol: begin
        command_address <= reg_pcm_vol;
        command_data    <= pcm_vol_data;
      end
      st_record_select: begin
        command_address <= reg_record_select;
        command_data    <= {5'b00000, source_mic, 5'b00000, source_mic};
      end
      st_record_gain: begin
        command_address <= reg_record_gain;
        command_data    <= record_gain_data;
      end
      st_mic_gain: begin
        command_address <= reg_mic_gain;
        command_data    <= mic_gain_data;
      end
      st_beep_vol: begin
        command_address <= reg_beep_vol;
        command_data    <= beep_vol_data;
      end
      st_pcm_bypass: begin
        command_address <= reg_general;
        command_data    <= general_data;
      end
      st_ext_audio: begin
        command_address <= reg_ext_audio;
        command_data    <= ext_audio_data;
      end
      st_adc_rate: begin
        command_address <= reg_adc_rate;
        command_data    <= adc_rate_data;
      end
      default: begin
        // read id and idle slots, harmless read
        command_address <= reg_read_id;
        command_data    <= read_id_data;
      end
    endcase
  end

endmodule

// ==== verilog/ac97_frame_engine.sv ====
`timescale 1ns/1ps

module ac97_frame_engine import ac97_link_pkg::*; (
  input  logic      ac97_bit_clock,
  input  logic      reset,            // sampled on the bit clock
  input  cmd_addr_t command_address,
  input  cmd_data_t command_data,
  input  logic      command_valid,
  input  slot_t     left_data,
  input  slot_t     right_data,
  input  logic      ac97_sdata_in,
  output logic      link_ready,
  output slot_t     left_in_data,
  output logic      ac97_sdata_out,
  output logic      ac97_synch
);

  bit_count_t bit_count;    // bit currently on the wire
  bit_count_t next_count;   // bit that starts on the coming edge
  bit_count_t slot_offset;  // position of next_count inside its slot
  logic [4:0] bit_index;    // payload bit for next_count, msb first

  // frame copies, stable for a whole frame
  slot_t l_cmd_addr, l_cmd_data, l_left_data, l_right_data;
  logic  l_cmd_v;

  always_comb begin
    next_count = bit_count + 1'b1;  // wraps 255 -> 0
    if (next_count >= right_first)
      slot_offset = next_count - right_first;
    else if (next_count >= left_first)
      slot_offset = next_count - left_first;
    else if (next_count >= cmd_data_first)
      slot_offset = next_count - cmd_data_first;
    else
      slot_offset = next_count - cmd_addr_first;  // junk in the tag slot, unused there
    bit_index = 5'(slot_bits - 1) - slot_offset[4:0];
  end

  ////////////////////
  // output side
  ////////////////////
  always_ff @(posedge ac97_bit_clock) begin
    if (reset) begin
      bit_count      <= 8'(frame_bits - 1);  // first edge out of reset opens a frame
      ac97_synch     <= 1'b0;
      link_ready     <= 1'b0;
      ac97_sdata_out <= 1'b0;
      l_cmd_v        <= 1'b0;
    end else begin
      bit_count  <= next_count;
      ac97_synch <= (next_count <= tag_last);  // high for the tag slot

      if (next_count == ready_rise_bit)
        link_ready <= 1'b1;
      else if (next_count == ready_fall_bit)
        link_ready <= 1'b0;

      if (bit_count == 8'(frame_bits - 1))
        l_cmd_v <= command_valid;

      if (next_count <= tag_last) begin
        case (next_count[3:0])
          4'd0:       ac97_sdata_out <= 1'b1;     // frame valid
          4'd1, 4'd2: ac97_sdata_out <= l_cmd_v;  // cmd addr / data valid
          4'd3, 4'd4: ac97_sdata_out <= 1'b1;     // left / right always valid
          default:    ac97_sdata_out <= 1'b0;
        endcase
      end else if (next_count < cmd_data_first)
        ac97_sdata_out <= l_cmd_v & l_cmd_addr[bit_index];
      else if (next_count < left_first)
        ac97_sdata_out <= l_cmd_v & l_cmd_data[bit_index];
      else if (next_count < right_first)
        ac97_sdata_out <= l_left_data[bit_index];
      else if (next_count <= right_last)
        ac97_sdata_out <= l_right_data[bit_index];
      else
        ac97_sdata_out <= 1'b0;  // slots 5..12 unused
    end
  end

  // user data taken at the last bit, goes out in the next frame
  always_ff @(posedge ac97_bit_clock) begin
    if (bit_count == 8'(frame_bits - 1)) begin
      l_cmd_addr   <= {command_address, 12'h000};  // left justified
      l_cmd_data   <= {command_data, 4'h0};
      l_left_data  <= left_data;
      l_right_data <= right_data;
    end
  end

  ////////////////////
  // input side
  ////////////////////
  // codec drives on rising edge, sample mid bit
  always_ff @(negedge ac97_bit_clock) begin
    if (bit_count >= left_first && bit_count < right_first)
      left_in_data <= {left_in_data[18:0], ac97_sdata_in};
  end

endmodule

// ==== verilog/ac97_audio_port.sv ====
`timescale 1ns/1ps

module ac97_audio_port import ac97_link_pkg::*, codec_ctrl_pkg::*; #(
  parameter int codec_reset_cycles = 1023
) (
  input  logic    clock_27mhz,
  input  logic    reset,
  input  volume_t volume,
  input  sample_t audio_out_data,   // playback sample
  input  logic    ac97_bit_clock,
  input  logic    ac97_sdata_in,
  output sample_t audio_in_data,    // record sample
  output logic    ready,            // one cycle per frame
  output logic    audio_reset_b,
  output logic    ac97_sdata_out,
  output logic    ac97_synch
);

  localparam int reset_count_bits = $clog2(codec_reset_cycles + 1);
  localparam logic [reset_count_bits-1:0] reset_done_count =
    reset_count_bits'(codec_reset_cycles);

  logic [reset_count_bits-1:0] reset_count;
  logic      link_ready;   // bit clock domain level
  logic [2:0] ready_sync;  // [1:0] synchronizer, [2] edge detect
  sample_t   out_data;
  slot_t     left_data, left_in_data;
  cmd_addr_t command_address;
  cmd_data_t command_data;
  logic      command_valid;

  // hold the codec in reset for a while after our reset
  always_ff @(posedge clock_27mhz) begin
    if (reset) begin
      reset_count   <= '0;
      audio_reset_b <= 1'b0;
    end else if (reset_count == reset_done_count)
      audio_reset_b <= 1'b1;
    else
      reset_count <= reset_count + 1'b1;
  end

  ////////////////////
  // ready crossing
  ////////////////////
  always_ff @(posedge clock_27mhz) begin
    if (reset) ready_sync <= '0;
    else       ready_sync <= {ready_sync[1:0], link_ready};
  end
  assign ready = ready_sync[1] & ~ready_sync[2];  // rising edge only

  always_ff @(posedge clock_27mhz) begin
    if (ready) out_data <= audio_out_data;  // hold for the engine's bit 255
  end

  assign left_data     = {out_data, 8'h00};  // 12 bit sample, msb aligned
  assign audio_in_data = left_in_data[19:8];

  ac97_frame_engine u_ac97_frame_engine (
    .ac97_bit_clock(ac97_bit_clock), .reset(reset),
    .command_address(command_address), .command_data(command_data),
    .command_valid(command_valid),
    .left_data(left_data), .right_data(left_data),  // mono, same on both
    .ac97_sdata_in(ac97_sdata_in), .link_ready(link_ready),
    .left_in_data(left_in_data), .ac97_sdata_out(ac97_sdata_out),
    .ac97_synch(ac97_synch)
  );

  codec_command_sequencer u_codec_command_sequencer (
    .clock_27mhz(clock_27mhz), .reset(reset), .ready(ready), .volume(volume),
    .command_address(command_address), .command_data(command_data),
    .command_valid(command_valid)
  );

endmodule

// ==== verilog/ac97_volume_top.sv ====
`timescale 1ns/1ps

module ac97_volume_top import codec_ctrl_pkg::*; #(
  parameter int debounce_cycles    = 270000,  // 10 ms at 27 mhz
  parameter int codec_reset_cycles = 1023
) (
  input  logic    clock_27mhz,
  input  logic    reset,
  input  logic    button_up,       // active low
  input  logic    button_down,     // active low
  input  sample_t audio_out_data,
  input  logic    ac97_bit_clock,
  input  logic    ac97_sdata_in,
  output sample_t audio_in_data,
  output logic    ready,
  output logic    audio_reset_b,
  output logic    ac97_sdata_out,
  output logic    ac97_synch
);

  volume_t volume;

  volume_control #(.debounce_cycles(debounce_cycles)) u_volume_control (
    .clock_27mhz(clock_27mhz), .reset(reset),
    .button_up(button_up), .button_down(button_down), .volume(volume)
  );

  // codec link and its command sequence
  ac97_audio_port #(.codec_reset_cycles(codec_reset_cycles)) u_ac97_audio_port (
    .clock_27mhz(clock_27mhz), .reset(reset), .volume(volume),
    .audio_out_data(audio_out_data), .ac97_bit_clock(ac97_bit_clock),
    .ac97_sdata_in(ac97_sdata_in), .audio_in_data(audio_in_data),
    .ready(ready), .audio_reset_b(audio_reset_b),
    .ac97_sdata_out(ac97_sdata_out), .ac97_synch(ac97_synch)
  );

endmodule

// ==== tests/ac97_frame_engine_assert.sv ====
`timescale 1ns/1ps

module ac97_frame_engine_assert import ac97_link_pkg::*; (
  input logic       ac97_bit_clock,
  input logic       reset,
  input bit_count_t bit_count,
  input logic       ac97_synch,
  input logic       ac97_sdata_out,
  input logic       link_ready
);

  // synch covers the tag slot only
  synch_window: assert property (@(posedge ac97_bit_clock) disable iff (reset)
    ac97_synch == (bit_count <= tag_last))
    else $error("ac97_synch wrong at bit %0d", bit_count);

  // slots 5 to 12 carry nothing
  tail_quiet: assert property (@(posedge ac97_bit_clock) disable iff (reset)
    bit_count > right_last |-> !ac97_sdata_out)
    else $error("ac97_sdata_out high at bit %0d", bit_count);

  ready_in_reset: assert property (@(posedge ac97_bit_clock)
    reset |=> !link_ready)
    else $error("link_ready high during reset");

endmodule

bind ac97_frame_engine ac97_frame_engine_assert u_frame_engine_assert (
  .ac97_bit_clock(ac97_bit_clock), .reset(reset), .bit_count(bit_count),
  .ac97_synch(ac97_synch), .ac97_sdata_out(ac97_sdata_out), .link_ready(link_ready)
);

// ==== tests/tb_ac97_volume_top.sv ====
`timescale 1ns/1ps

module tb_ac97_volume_top
  import ac97_link_pkg::*, codec_ctrl_pkg::*;
();

  localparam int debounce_cycles    = 8;
  localparam int codec_reset_cycles = 16;
  localparam int table_len          = 8;
  localparam int frames_per_test    = 24;       // 3 sample frames, buttons, up to 18 for headphone
  localparam int frame_cycles       = 256 * 4;  // bit clock is 4x slower
  localparam int timeout_cycles     =
    (table_len * frames_per_test * frame_cycles + 16 + codec_reset_cycles + 2) * 5 / 4;

  localparam int act_none = 0;
  localparam int act_up   = 1;
  localparam int act_down = 2;

  ////////////////////
  // stimulus table
  ////////////////////
  sample_t play_table [table_len] = '{12'h5A3, 12'hFFF, 12'h001, 12'h800,
                                      12'h7FF, 12'hC3C, 12'h000, 12'h9E1};
  int act_table  [table_len] = '{act_none, act_up, act_down, act_up,
                                 act_up, act_down, act_down, act_up};
  int reps_table [table_len] = '{0, 3, 5, 30, 2, 40, 1, 1};  // presses per entry
  int vol_table  [table_len] = '{8, 11, 6, 31, 31, 0, 0, 1};  // saturates at both ends
  sample_t rec_table [table_len];                             // from $random

  // expected slot 1 address, one per sequencer state
  cmd_addr_t cmd_order [16] = '{reg_read_id, reg_read_id, reg_read_id, reg_headphone_vol,
                                reg_read_id, reg_pcm_vol, reg_record_select, reg_record_gain,
                                reg_read_id, reg_mic_gain, reg_beep_vol, reg_general,
                                reg_ext_audio, reg_adc_rate, reg_read_id, reg_read_id};

  logic    clock_27mhz;
  logic    reset;
  logic    button_up;
  logic    button_down;
  sample_t audio_out_data;
  logic    ac97_bit_clock;
  logic    ac97_sdata_in = 1'b0;
  sample_t audio_in_data;
  logic    ready;
  logic    audio_reset_b;
  logic    ac97_sdata_out;
  logic    ac97_synch;

  // codec model state
  logic [255:0] cur_frame;
  logic [255:0] last_frame;       // most recent complete frame
  bit_count_t   bit_pos = '0;     // bit on the wire, as seen by the codec
  bit_count_t   drive_pos;
  logic         aligned = 1'b0;
  logic         synch_prev = 1'b0;
  int           frame_count = 0;
  sample_t      rec_drive = '0;
  slot_t        rec_slot;

  int cycles = 0;
  int error_count = 0;
  int tests_run = 0;
  int tests_failed = 0;

  assign rec_slot = {rec_drive, ~rec_drive[7:0]};  // junk low byte, dropped by the port

  ac97_volume_top #(
    .debounce_cycles(debounce_cycles), .codec_reset_cycles(codec_reset_cycles)
  ) u_ac97_volume_top (
    .clock_27mhz(clock_27mhz), .reset(reset),
    .button_up(button_up), .button_down(button_down),
    .audio_out_data(audio_out_data), .ac97_bit_clock(ac97_bit_clock),
    .ac97_sdata_in(ac97_sdata_in), .audio_in_data(audio_in_data),
    .ready(ready), .audio_reset_b(audio_reset_b),
    .ac97_sdata_out(ac97_sdata_out), .ac97_synch(ac97_synch)
  );

  initial begin
    clock_27mhz = 1'b0;
    forever #10 clock_27mhz = ~clock_27mhz;
  end

  initial begin
    ac97_bit_clock = 1'b0;
    #7;  // keeps bit clock edges off the system clock edges
    forever #40 ac97_bit_clock = ~ac97_bit_clock;
  end

  always @(posedge clock_27mhz) begin
    cycles <= cycles + 1;
    if (cycles == timeout_cycles) begin
      $display("timeout after %0d cycles, the test sequence did not finish", cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
      error_count = error_count + 1;
    end
  endtask

  function automatic slot_t slot_at(input logic [255:0] frame, input int first);
    slot_t s;
    for (int i = 0; i < slot_bits; i++)
      s[slot_bits - 1 - i] = frame[first + i];  // msb first on the wire
    return s;
  endfunction

  task automatic check_frame(input logic [255:0] frame, input int number);
    slot_t addr_slot;
    slot_t data_slot;
    addr_slot = slot_at(frame, cmd_addr_first);
    data_slot = slot_at(frame, cmd_data_first);
    check("tag frame valid", frame[0], 1'b1);
    check("tag left valid", frame[3], 1'b1);
    check("tag right valid", frame[4], 1'b1);
    if (number >= 1) begin  // first frame may still go out without a command
      check("tag command address valid", frame[1], 1'b1);
      check("tag command data valid", frame[2], 1'b1);
    end
    if (frame[1]) begin
      check("command address", addr_slot[19:12], cmd_order[number % 16]);
      if (addr_slot[19:12] == reg_record_select)
        check("record select data", data_slot[19:4], {5'b0, source_mic, 5'b0, source_mic});
    end
  endtask

  ////////////////////
  // codec model
  ////////////////////
  always @(negedge ac97_bit_clock) begin
    if (ac97_synch && !synch_prev) begin
      if (aligned)
        check("synch rise position", bit_pos, 8'd255);  // 256 bit period
      aligned = 1'b1;
      bit_pos = '0;
    end else if (aligned) begin
      bit_pos = bit_pos + 8'd1;
    end
    synch_prev = ac97_synch;
    if (aligned) begin
      check("ac97_synch", ac97_synch, bit_pos <= tag_last);
      cur_frame[bit_pos] = ac97_sdata_out;
      if (bit_pos == 8'd255) begin
        last_frame = cur_frame;
        check_frame(cur_frame, frame_count);
        frame_count = frame_count + 1;
      end
    end
  end

  // record slot, driven from the edge that opens each bit
  always @(posedge ac97_bit_clock) begin
    drive_pos = bit_pos + 8'd1;
    if (aligned && drive_pos >= left_first && drive_pos < right_first)
      ac97_sdata_in <= rec_slot[slot_bits - 1 - (drive_pos - left_first)];
    else
      ac97_sdata_in <= 1'b0;
  end

  task automatic wait_ready();
    @(negedge clock_27mhz);
    while (!ready) @(negedge clock_27mhz);
  endtask

  task automatic wait_frame();
    int count;
    count = frame_count;
    while (frame_count == count) @(negedge clock_27mhz);
  endtask

  task automatic press(input int action);
    if (action == act_up)
      button_up = 1'b0;  // active low
    else if (action == act_down)
      button_down = 1'b0;
    repeat (debounce_cycles + 4) @(negedge clock_27mhz);
    button_up   = 1'b1;
    button_down = 1'b1;
    repeat (debounce_cycles + 4) @(negedge clock_27mhz);
  endtask

  task automatic check_headphone(input int vol);
    int         waited;
    logic       found;
    slot_t      data_slot;
    logic [4:0] atten;
    waited = 0;
    found  = 1'b0;
    atten  = 5'(31 - vol);
    wait_frame();  // frame in flight may hold the old volume
    while (!found && waited < 20) begin
      wait_frame();
      waited = waited + 1;
      found  = (slot_at(last_frame, cmd_addr_first) >> 12) == reg_headphone_vol;
    end
    if (!found) begin
      $display("no headphone volume command seen within 20 frames");
      error_count = error_count + 1;
    end else begin
      data_slot = slot_at(last_frame, cmd_data_first);
      check("headphone volume data", data_slot[19:4], {3'b000, atten, 3'b000, atten});
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run = tests_run + 1;
    if (error_count == errors_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: failed", name);
      tests_failed = tests_failed + 1;
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    int seed;
    int errors_before;
    seed           = 32'h676d_6a8e;
    reset          = 1'b1;
    button_up      = 1'b1;
    button_down    = 1'b1;
    audio_out_data = '0;
    for (int i = 0; i < table_len; i++)
      rec_table[i] = sample_t'($random(seed));

    errors_before = error_count;
    repeat (15) @(negedge clock_27mhz);
    check("audio_reset_b", audio_reset_b, 1'b0);
    check("ready", ready, 1'b0);
    check("ac97_synch", ac97_synch, 1'b0);
    @(negedge clock_27mhz);
    reset = 1'b0;  // 16 cycles held
    repeat (codec_reset_cycles) @(negedge clock_27mhz);
    check("audio_reset_b", audio_reset_b, 1'b0);  // codec still held
    repeat (2) @(negedge clock_27mhz);
    check("audio_reset_b", audio_reset_b, 1'b1);
    report_test("reset", errors_before);

    for (int t = 0; t < table_len; t++) begin
      errors_before = error_count;
      wait_ready();
      audio_out_data = play_table[t];  // latched on this ready cycle
      rec_drive      = rec_table[t];   // goes into the next frame's slot 3
      wait_ready();
      check("audio_in_data", audio_in_data, rec_table[t]);
      wait_ready();
      check("left slot", slot_at(last_frame, left_first), {play_table[t], 8'h00});
      check("right slot", slot_at(last_frame, right_first), {play_table[t], 8'h00});
      repeat (reps_table[t]) press(act_table[t]);
      check_headphone(vol_table[t]);
      report_test($sformatf("test %0d sample %h volume %0d", t, play_table[t], vol_table[t]),
                  errors_before);
    end

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== project.f ====
verilog/ac97_link_pkg.sv
verilog/codec_ctrl_pkg.sv
verilog/button_debounce.sv
verilog/volume_control.sv
verilog/codec_command_sequencer.sv
verilog/ac97_frame_engine.sv
verilog/ac97_audio_port.sv
verilog/ac97_volume_top.sv
tests/ac97_frame_engine_assert.sv
tests/tb_ac97_volume_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with verilator
cd "$(dirname "$0")" || exit 1

top=tb_ac97_volume_top
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module "$top" -o "V$top"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./obj_dir/V$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" "$log"; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation passed"
exit 0
